// ==== src/btb_defs.svh ====
// Branch target buffer sizing

`ifndef BTB_DEFS_SVH
`define BTB_DEFS_SVH

// Fully associative, one tag compare per entry
`define BTB_ENTRY_NUM 16

// Fetch and branch address width
`define BTB_PC_WIDTH 40

// Low PC bits kept as tag and as stored target.
// The upper bits always come from the fetch PC.
`define BTB_TAG_WIDTH 16

`endif

// ==== src/btb_pc_pkg.sv ====
// Branch target buffer address types

`include "btb_defs.svh"

package btb_pc_pkg;

  // Full fetch or branch PC
  typedef logic [`BTB_PC_WIDTH-1:0] pc_t;

  // Low address bits, used for tag compare and stored target
  typedef logic [`BTB_TAG_WIDTH-1:0] tag_t;

  // Upper PC bits taken from the fetch PC on a prediction
  typedef logic [`BTB_PC_WIDTH-`BTB_TAG_WIDTH-1:0] pc_hi_t;

endpackage

// ==== src/btb_ctrl_pkg.sv ====
// Branch target buffer control structures

`include "btb_defs.svh"

package btb_ctrl_pkg;

  // One bit per buffer entry
  typedef logic [`BTB_ENTRY_NUM-1:0] entry_vec_t;

  // Fetch request from the fetch controller
  typedef struct packed {
    logic              inst_fetch;
    logic              grant;
    logic              stall;
    btb_pc_pkg::pc_t   ifpc;
  } btb_fetch_t;

  // Branch update from predecode
  typedef struct packed {
    logic              upd_vld;
    logic              mis_pred;
    btb_pc_pkg::pc_t   cur_pc;
    btb_pc_pkg::pc_t   tar_pc;
  } btb_upd_t;

  // Predecode and controller feedback on the held target
  typedef struct packed {
    logic              pred_chgflw_vld;
    logic              ctrl_chgflw_vld;
    logic              inst_vld;
    logic              stall;
  } btb_pred_fb_t;

  // Write data broadcast to every entry
  typedef struct packed {
    btb_pc_pkg::tag_t  tag;
    btb_pc_pkg::tag_t  tgt;
  } btb_entry_wr_t;

endpackage

// ==== src/btb_entry.sv ====
// Branch target buffer entry

`timescale 1ns/1ps

module btb_entry (
  input  logic                      btb_clk,
  input  logic                      cpurst_b,
  input  btb_ctrl_pkg::btb_entry_wr_t wr,
  input  logic                      upd,
  input  logic                      clr,
  input  btb_pc_pkg::tag_t          rd_tag,
  output logic                      rd_hit,
  output logic                      wr_hit,
  output btb_pc_pkg::tag_t          tgt
);

  logic              entry_vld;
  btb_pc_pkg::tag_t  entry_tag;
  btb_pc_pkg::tag_t  entry_tgt;

  //--------------------------------------------------------------------------
  // Entry state
  //--------------------------------------------------------------------------
  // Clear beats update on the same edge
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (clr)
      entry_vld <= 1'b0;
    else if (upd)
      entry_vld <= 1'b1;
  end

  // Tag and target only matter while valid
  always_ff @(posedge btb_clk)
  begin
    if (upd)
    begin
      entry_tag <= wr.tag;
      entry_tgt <= wr.tgt;
    end
  end

  //--------------------------------------------------------------------------
  // Tag compare
  //--------------------------------------------------------------------------
  // Fetch side lookup
  assign rd_hit = entry_vld && (entry_tag == rd_tag);

  // Update side lookup, drives replace and mispredict clear
  assign wr_hit = entry_vld && (entry_tag == wr.tag);

  assign tgt = entry_tgt;

endmodule

// ==== src/btb_write_ctrl.sv ====
// Branch target buffer write control

`timescale 1ns/1ps

`include "btb_defs.svh"

module btb_write_ctrl (
  input  logic                        btb_clk,
  input  logic                        cpurst_b,
  input  btb_ctrl_pkg::btb_upd_t      upd,
  input  logic                        btb_en,
  input  logic                        btb_clr,
  input  btb_ctrl_pkg::entry_vec_t    wr_hit,
  output btb_ctrl_pkg::btb_entry_wr_t entry_wr,
  output btb_ctrl_pkg::entry_vec_t    entry_upd,
  output btb_ctrl_pkg::entry_vec_t    entry_clr
);

  logic                      wr_hit_vld;
  logic                      upd_vld_en;
  logic                      clr_one;
  logic                      replace;
  btb_ctrl_pkg::entry_vec_t  fifo_ptr;

  assign wr_hit_vld = |wr_hit;

  //--------------------------------------------------------------------------
  // Clear decode
  //--------------------------------------------------------------------------
  // Mispredict drops only the matching entry
  assign clr_one = upd.mis_pred && btb_en && wr_hit_vld;

  // Global clear hits every entry
  assign entry_clr = ({`BTB_ENTRY_NUM{clr_one}} & wr_hit)
                   | {`BTB_ENTRY_NUM{btb_clr}};

  //--------------------------------------------------------------------------
  // Update decode
  //--------------------------------------------------------------------------
  assign upd_vld_en = upd.upd_vld && btb_en;

  // Existing tag is rewritten in place, otherwise take the FIFO slot
  assign replace = upd_vld_en && wr_hit_vld;

  assign entry_upd = replace ? wr_hit
                             : ({`BTB_ENTRY_NUM{upd_vld_en}} & fifo_ptr);

  assign entry_wr.tag = upd.cur_pc[`BTB_TAG_WIDTH-1:0];
  assign entry_wr.tgt = upd.tar_pc[`BTB_TAG_WIDTH-1:0];

  //--------------------------------------------------------------------------
  // Round-robin replacement pointer
  //--------------------------------------------------------------------------
  // Rotates on an allocating update; a mispredict clear points
  // it at the freed entry so that slot gets reused first
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      fifo_ptr <= btb_ctrl_pkg::entry_vec_t'(1);
    else if (upd_vld_en && !wr_hit_vld)
      fifo_ptr <= {fifo_ptr[`BTB_ENTRY_NUM-2:0], fifo_ptr[`BTB_ENTRY_NUM-1]};
    else if (clr_one)
      fifo_ptr <= wr_hit;
  end

  // Tags are unique across entries, so the reloaded hit vector stays one-hot
  ap_fifo_onehot: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b)
    $onehot(fifo_ptr)
  ) else $error("btb fifo pointer not one-hot: %h", fifo_ptr);

endmodule

// ==== src/btb_read_pred.sv ====
// Branch target buffer read and predict stage

`timescale 1ns/1ps

`include "btb_defs.svh"

module btb_read_pred (
  input  logic                       btb_clk,
  input  logic                       cpurst_b,
  input  btb_ctrl_pkg::btb_fetch_t   fetch,
  input  logic                       mis_pred,
  input  logic                       btb_en,
  input  logic                       iu_tar_pc_vld,
  input  btb_ctrl_pkg::btb_pred_fb_t fb,
  input  btb_ctrl_pkg::entry_vec_t   rd_hit,
  input  btb_pc_pkg::tag_t           tgt_vec [`BTB_ENTRY_NUM],
  output btb_pc_pkg::pc_t            pcgen_tar_pc,
  output btb_pc_pkg::pc_t            pred_tar_pc,
  output logic                       pred_tar_vld,
  output logic                       chgflw_vld
);

  logic                      rd_hit_vld;
  logic                      fetch_acc;
  logic                      pred_flop;
  logic                      chgflw_set;
  logic                      tar_vld;
  btb_ctrl_pkg::entry_vec_t  hit_flop;
  btb_pc_pkg::tag_t          hit_tgt;
  btb_pc_pkg::pc_hi_t        ifpc_hi;
  btb_pc_pkg::pc_t           tar_pc;

  //--------------------------------------------------------------------------
  // Hit capture
  //--------------------------------------------------------------------------
  assign rd_hit_vld = |rd_hit;

  // Granted fetch that hits, no mispredict in flight, not stalled
  assign fetch_acc = fetch.inst_fetch && fetch.grant && rd_hit_vld
                  && !mis_pred && !fetch.stall;

  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hit_flop <= '0;
    else if (fetch_acc)
      hit_flop <= rd_hit;
  end

  // One cycle change of flow after an accepted hit
  // A redirect from the IU on the same edge takes priority
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pred_flop <= 1'b0;
    else
      pred_flop <= fetch_acc && btb_en && !iu_tar_pc_vld;
  end

  //--------------------------------------------------------------------------
  // Target select
  //--------------------------------------------------------------------------
  // OR of the one-hot selected targets
  always_comb
  begin
    hit_tgt = '0;
    for (int i = 0; i < `BTB_ENTRY_NUM; i++)
    begin
      if (hit_flop[i])
        hit_tgt = hit_tgt | tgt_vec[i];
    end
  end

  assign ifpc_hi      = fetch.ifpc[`BTB_PC_WIDTH-1:`BTB_TAG_WIDTH];
  assign pcgen_tar_pc = {ifpc_hi, hit_tgt};

  //--------------------------------------------------------------------------
  // Held target for predecode
  //--------------------------------------------------------------------------
  // Only held when nobody else redirected in the same cycle
  assign chgflw_set = pred_flop && !fb.pred_chgflw_vld && !fb.ctrl_chgflw_vld;

  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tar_vld <= 1'b0;
    else if (fb.ctrl_chgflw_vld)
      tar_vld <= 1'b0;
    else if (chgflw_set)
      tar_vld <= 1'b1;
    else if (tar_vld && fb.inst_vld && !fb.stall)
      tar_vld <= 1'b0;
  end

  always_ff @(posedge btb_clk)
  begin
    if (chgflw_set)
      tar_pc <= pcgen_tar_pc;
  end

  assign pred_tar_vld = tar_vld;
  assign pred_tar_pc  = tar_pc;
  assign chgflw_vld   = pred_flop;

  // Entry tags are unique, so at most one entry can have matched
  ap_hit_onehot0: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b)
    $onehot0(hit_flop)
  ) else $error("btb hit register has multiple bits set: %h", hit_flop);

endmodule

// ==== src/btb_top.sv ====
// Branch target buffer top level

`timescale 1ns/1ps

`include "btb_defs.svh"

module btb_top (
  input  logic                       btb_clk,
  input  logic                       cpurst_b,
  input  btb_ctrl_pkg::btb_fetch_t   fetch,
  input  btb_ctrl_pkg::btb_upd_t     upd,
  input  btb_ctrl_pkg::btb_pred_fb_t fb,
  input  logic                       iu_tar_pc_vld,
  input  logic                       btb_en,
  input  logic                       btb_clr,
  output btb_pc_pkg::pc_t            pcgen_tar_pc,
  output logic                       pred_tar_vld,
  output btb_pc_pkg::pc_t            pred_tar_pc,
  output logic                       chgflw_vld
);

  btb_ctrl_pkg::btb_entry_wr_t  entry_wr;
  btb_ctrl_pkg::entry_vec_t     entry_upd;
  btb_ctrl_pkg::entry_vec_t     entry_clr;
  btb_ctrl_pkg::entry_vec_t     rd_hit;
  btb_ctrl_pkg::entry_vec_t     wr_hit;
  btb_pc_pkg::tag_t             tgt_vec [`BTB_ENTRY_NUM];

  //--------------------------------------------------------------------------
  // Write port
  //--------------------------------------------------------------------------
  btb_write_ctrl u_write_ctrl (
    .btb_clk   (btb_clk),
    .cpurst_b  (cpurst_b),
    .upd       (upd),
    .btb_en    (btb_en),
    .btb_clr   (btb_clr),
    .wr_hit    (wr_hit),
    .entry_wr  (entry_wr),
    .entry_upd (entry_upd),
    .entry_clr (entry_clr)
  );

  //--------------------------------------------------------------------------
  // Entries
  //--------------------------------------------------------------------------
  for (genvar i = 0; i < `BTB_ENTRY_NUM; i++)
  begin : g_entry
    btb_entry u_entry (
      .btb_clk  (btb_clk),
      .cpurst_b (cpurst_b),
      .wr       (entry_wr),
      .upd      (entry_upd[i]),
      .clr      (entry_clr[i]),
      .rd_tag   (fetch.ifpc[`BTB_TAG_WIDTH-1:0]),
      .rd_hit   (rd_hit[i]),
      .wr_hit   (wr_hit[i]),
      .tgt      (tgt_vec[i])
    );
  end

  //--------------------------------------------------------------------------
  // Read port and prediction
  //--------------------------------------------------------------------------
  btb_read_pred u_read_pred (
    .btb_clk       (btb_clk),
    .cpurst_b      (cpurst_b),
    .fetch         (fetch),
    .mis_pred      (upd.mis_pred),
    .btb_en        (btb_en),
    .iu_tar_pc_vld (iu_tar_pc_vld),
    .fb            (fb),
    .rd_hit        (rd_hit),
    .tgt_vec       (tgt_vec),
    .pcgen_tar_pc  (pcgen_tar_pc),
    .pred_tar_pc   (pred_tar_pc),
    .pred_tar_vld  (pred_tar_vld),
    .chgflw_vld    (chgflw_vld)
  );

endmodule

// ==== test/btb_clk_gen.sv ====
// Testbench clock and reset

`timescale 1ns/1ps

module btb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 4
) (
  output logic btb_clk,
  output logic cpurst_b
);

  initial
  begin
    btb_clk = 1'b0;
    forever #(PERIOD / 2) btb_clk = ~btb_clk;
  end

  // Release just after an edge, like the rest of the stimulus
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge btb_clk);
    #2;
    cpurst_b = 1'b1;
  end

endmodule

// ==== test/btb_tb.sv ====
// Branch target buffer testbench

`timescale 1ns/1ps

`include "btb_defs.svh"

module btb_tb;

  logic                        btb_clk;
  logic                        cpurst_b;
  btb_ctrl_pkg::btb_fetch_t    fetch;
  btb_ctrl_pkg::btb_upd_t      upd;
  btb_ctrl_pkg::btb_pred_fb_t  fb;
  logic                        iu_tar_pc_vld;
  logic                        btb_en;
  logic                        btb_clr;
  btb_pc_pkg::pc_t             pcgen_tar_pc;
  logic                        pred_tar_vld;
  btb_pc_pkg::pc_t             pred_tar_pc;
  logic                        chgflw_vld;

  // Inputs for the coming cycle
  btb_ctrl_pkg::btb_fetch_t    nx_fetch;
  btb_ctrl_pkg::btb_upd_t      nx_upd;
  btb_ctrl_pkg::btb_pred_fb_t  nx_fb;
  logic                        nx_iu;
  logic                        nx_en;
  logic                        nx_clr;
  bit                          fb_random;
  integer                      seed;
  btb_pc_pkg::pc_t             probe_pc;

  // Reference model state
  logic                        m_vld [`BTB_ENTRY_NUM];
  btb_pc_pkg::tag_t            m_tag [`BTB_ENTRY_NUM];
  btb_pc_pkg::tag_t            m_tgt [`BTB_ENTRY_NUM];
  btb_ctrl_pkg::entry_vec_t    m_ptr;
  btb_ctrl_pkg::entry_vec_t    m_hit;
  logic                        m_chg;
  logic                        m_tvld;
  btb_pc_pkg::pc_t             m_tpc;

  btb_clk_gen u_clk_gen (
    .btb_clk  (btb_clk),
    .cpurst_b (cpurst_b)
  );

  btb_top btb_top_inst (
    .btb_clk       (btb_clk),
    .cpurst_b      (cpurst_b),
    .fetch         (fetch),
    .upd           (upd),
    .fb            (fb),
    .iu_tar_pc_vld (iu_tar_pc_vld),
    .btb_en        (btb_en),
    .btb_clr       (btb_clr),
    .pcgen_tar_pc  (pcgen_tar_pc),
    .pred_tar_vld  (pred_tar_vld),
    .pred_tar_pc   (pred_tar_pc),
    .chgflw_vld    (chgflw_vld)
  );

  //--------------------------------------------------------------------------
  // Failure reporting and random helpers
  //--------------------------------------------------------------------------
  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp)
    else
      stop_on_failure($sformatf("ERROR at %0t ns: %s expected %h got %h",
                                $time, name, exp, got));
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond)
    else
      stop_on_failure(msg);
  endtask

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic btb_pc_pkg::pc_hi_t rand_hi();
    return btb_pc_pkg::pc_hi_t'($random(seed));
  endfunction

  // Small tag pool so that random updates and fetches collide
  function automatic btb_pc_pkg::tag_t pool_tag();
    int k;
    k = $unsigned($random(seed)) % 24;
    return btb_pc_pkg::tag_t'(16'h0040 + k * 16'h0104);
  endfunction

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------
  function automatic btb_ctrl_pkg::entry_vec_t model_lookup(input btb_pc_pkg::tag_t tag);
    btb_ctrl_pkg::entry_vec_t v;
    v = '0;
    for (int i = 0; i < `BTB_ENTRY_NUM; i++)
      v[i] = m_vld[i] && (m_tag[i] == tag);
    return v;
  endfunction

  // Fetch PC upper bits joined with the target of the registered hit
  function automatic btb_pc_pkg::pc_t model_pcgen();
    btb_pc_pkg::tag_t t;
    t = '0;
    for (int i = 0; i < `BTB_ENTRY_NUM; i++)
      if (m_hit[i])
        t = m_tgt[i];
    return {fetch.ifpc[`BTB_PC_WIDTH-1:`BTB_TAG_WIDTH], t};
  endfunction

  // Advance the model across one rising edge with the applied inputs
  task automatic model_step();
    btb_ctrl_pkg::entry_vec_t wr_hit;
    btb_ctrl_pkg::entry_vec_t rd_hit;
    btb_ctrl_pkg::entry_vec_t clr_v;
    btb_ctrl_pkg::entry_vec_t upd_v;
    btb_pc_pkg::pc_t          pc_now;
    logic                     upd_en;
    logic                     clr_one;
    logic                     acc;
    logic                     chg_set;
    wr_hit  = model_lookup(upd.cur_pc[`BTB_TAG_WIDTH-1:0]);
    rd_hit  = model_lookup(fetch.ifpc[`BTB_TAG_WIDTH-1:0]);
    pc_now  = model_pcgen();
    upd_en  = upd.upd_vld && btb_en;
    clr_one = upd.mis_pred && btb_en && (wr_hit != 0);
    clr_v   = btb_clr ? '1 : (clr_one ? wr_hit : '0);
    if (!upd_en)
      upd_v = '0;
    else if (wr_hit != 0)
      upd_v = wr_hit;
    else
      upd_v = m_ptr;
    for (int i = 0; i < `BTB_ENTRY_NUM; i++)
    begin
      if (upd_v[i])
      begin
        m_tag[i] = upd.cur_pc[`BTB_TAG_WIDTH-1:0];
        m_tgt[i] = upd.tar_pc[`BTB_TAG_WIDTH-1:0];
      end
      if (clr_v[i])
        m_vld[i] = 1'b0;
      else if (upd_v[i])
        m_vld[i] = 1'b1;
    end
    if (upd_en && (wr_hit == 0))
      m_ptr = {m_ptr[`BTB_ENTRY_NUM-2:0], m_ptr[`BTB_ENTRY_NUM-1]};
    else if (clr_one)
      m_ptr = wr_hit;
    acc = fetch.inst_fetch && fetch.grant && (rd_hit != 0) && !upd.mis_pred && !fetch.stall;
    chg_set = m_chg && !fb.pred_chgflw_vld && !fb.ctrl_chgflw_vld;
    if (fb.ctrl_chgflw_vld)
      m_tvld = 1'b0;
    else if (chg_set)
      m_tvld = 1'b1;
    else if (fb.inst_vld && !fb.stall)
      m_tvld = 1'b0;
    if (chg_set)
      m_tpc = pc_now;
    m_chg = acc && btb_en && !iu_tar_pc_vld;
    if (acc)
      m_hit = rd_hit;
  endtask

  //--------------------------------------------------------------------------
  // Cycle driver
  //--------------------------------------------------------------------------
  task automatic run_cycle();
    @(posedge btb_clk);
    #2;
    if (fb_random)
    begin
      nx_fb.pred_chgflw_vld = chance(10);
      nx_fb.ctrl_chgflw_vld = chance(10);
      nx_fb.inst_vld        = chance(50);
      nx_fb.stall           = chance(20);
    end
    fetch         = nx_fetch;
    upd           = nx_upd;
    fb            = nx_fb;
    iu_tar_pc_vld = nx_iu;
    btb_en        = nx_en;
    btb_clr       = nx_clr;
    @(negedge btb_clk);
    check_val("chgflw_vld", m_chg, chgflw_vld);
    check_val("pred_tar_vld", m_tvld, pred_tar_vld);
    if (m_tvld)
      check_val("pred_tar_pc", m_tpc, pred_tar_pc);
    check_val("pcgen_tar_pc", model_pcgen(), pcgen_tar_pc);
    model_step();
  endtask

  task automatic do_update(input btb_pc_pkg::tag_t tag, input btb_pc_pkg::tag_t tgt);
    nx_upd.upd_vld  = 1'b1;
    nx_upd.mis_pred = 1'b0;
    nx_upd.cur_pc   = {rand_hi(), tag};
    nx_upd.tar_pc   = {rand_hi(), tgt};
    run_cycle();
    nx_upd = '0;
  endtask

  task automatic mispredict(input btb_pc_pkg::tag_t tag);
    nx_upd          = '0;
    nx_upd.mis_pred = 1'b1;
    nx_upd.cur_pc   = {rand_hi(), tag};
    run_cycle();
    nx_upd = '0;
  endtask

  // Granted fetch of tag, then wait with ifpc held for the change of flow
  task automatic probe(input btb_pc_pkg::tag_t tag, input bit iu, input bit expect_hit,
                       input btb_pc_pkg::tag_t exp_tgt);
    btb_pc_pkg::pc_hi_t hi;
    int                 waited;
    bit                 seen;
    hi = rand_hi();
    nx_fetch.inst_fetch = 1'b1;
    nx_fetch.grant      = 1'b1;
    nx_fetch.stall      = 1'b0;
    nx_fetch.ifpc       = {hi, tag};
    nx_iu               = iu;
    run_cycle();
    nx_fetch.inst_fetch = 1'b0;
    nx_fetch.grant      = 1'b0;
    nx_iu               = 1'b0;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < 3)
    begin
      run_cycle();
      waited++;
      seen = chgflw_vld;
    end
    probe_pc = {hi, exp_tgt};
    if (expect_hit)
    begin
      check_true(seen && waited == 1, "chgflw_vld did not follow an accepted hit by one cycle");
      check_val("pcgen_tar_pc", probe_pc, pcgen_tar_pc);
    end
    else
      check_true(!seen, "chgflw_vld was raised where no prediction was expected");
  endtask

  // The target is captured at the edge after chgflw_vld
  task automatic wait_tar_vld();
    int waited;
    waited = 0;
    do
    begin
      run_cycle();
      waited++;
    end
    while (!pred_tar_vld && waited < 3);
    check_true(pred_tar_vld, "timed out waiting for pred_tar_vld after a prediction");
    check_val("pred_tar_pc", probe_pc, pred_tar_pc);
  endtask

  task automatic random_inputs();
    nx_fetch.inst_fetch = chance(60);
    nx_fetch.grant      = chance(80);
    nx_fetch.stall      = chance(15);
    nx_fetch.ifpc       = {rand_hi(), pool_tag()};
    nx_upd.upd_vld      = chance(25);
    nx_upd.mis_pred     = chance(8);
    nx_upd.cur_pc       = {rand_hi(), pool_tag()};
    nx_upd.tar_pc       = {rand_hi(), btb_pc_pkg::tag_t'($random(seed))};
    nx_iu               = chance(10);
    nx_en               = chance(92);
    nx_clr              = chance(2);
  endtask

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial
  begin
    int i;
    seed      = 32'hf2b5_0bec;
    fb_random = 1'b0;
    nx_fetch  = '0;
    nx_upd    = '0;
    nx_fb     = '0;
    nx_iu     = 1'b0;
    nx_en     = 1'b1;
    nx_clr    = 1'b0;
    fetch     = '0;
    upd       = '0;
    fb        = '0;
    iu_tar_pc_vld = 1'b0;
    btb_en    = 1'b1;
    btb_clr   = 1'b0;
    for (int k = 0; k < `BTB_ENTRY_NUM; k++)
    begin
      m_vld[k] = 1'b0;
      m_tag[k] = '0;
      m_tgt[k] = '0;
    end
    m_ptr  = btb_ctrl_pkg::entry_vec_t'(1);
    m_hit  = '0;
    m_chg  = 1'b0;
    m_tvld = 1'b0;
    m_tpc  = '0;

    i = 0;
    while (!cpurst_b && i < 20)
    begin
      @(posedge btb_clk);
      i++;
    end
    check_true(cpurst_b, "reset was never released");

    // Empty buffer never predicts
    fb_random = 1'b1;
    for (int k = 0; k < 40; k++)
    begin
      random_inputs();
      nx_upd = '0;
      nx_clr = 1'b0;
      run_cycle();
      check_true(!chgflw_vld && !pred_tar_vld, "prediction raised with an empty buffer");
    end
    nx_fetch = '0;
    nx_iu    = 1'b0;
    nx_en    = 1'b1;

    // Single update then hit
    do_update(16'h3a50, 16'h7c24);
    probe(16'h3a50, 1'b0, 1'b1, 16'h7c24);

    // FIFO eviction and in-place rewrite
    nx_clr = 1'b1;
    run_cycle();
    nx_clr = 1'b0;
    for (int k = 0; k < 17; k++)
      do_update(btb_pc_pkg::tag_t'(16'h5000 + k * 16'h0111), btb_pc_pkg::tag_t'(16'ha000 + k));
    probe(16'h5000, 1'b0, 1'b0, 16'h0);
    probe(16'h5111, 1'b0, 1'b1, 16'ha001);
    probe(btb_pc_pkg::tag_t'(16'h5000 + 16 * 16'h0111), 1'b0, 1'b1, 16'ha010);
    do_update(16'h5555, 16'hbeef);
    probe(16'h5555, 1'b0, 1'b1, 16'hbeef);
    do_update(16'h6000, 16'h6001);
    probe(16'h5111, 1'b0, 1'b0, 16'h0);
    probe(16'h5222, 1'b0, 1'b1, 16'ha002);

    // Mispredict drops one entry, and its slot is reused first
    mispredict(16'h5777);
    probe(16'h5777, 1'b0, 1'b0, 16'h0);
    probe(16'h5888, 1'b0, 1'b1, 16'ha008);
    do_update(16'h6100, 16'h6101);
    probe(16'h5222, 1'b0, 1'b1, 16'ha002);
    nx_clr = 1'b1;
    run_cycle();
    nx_clr = 1'b0;
    probe(16'h5888, 1'b0, 1'b0, 16'h0);
    probe(16'h6100, 1'b0, 1'b0, 16'h0);

    // Held target with directed feedback
    fb_random = 1'b0;
    nx_fb     = '0;
    do_update(16'h4242, 16'h9a9a);
    probe(16'h4242, 1'b0, 1'b1, 16'h9a9a);
    wait_tar_vld();
    nx_fb.inst_vld = 1'b1;
    nx_fb.stall    = 1'b1;
    run_cycle();
    run_cycle();
    check_true(pred_tar_vld, "pred_tar_vld dropped while predecode was stalled");
    nx_fb.stall = 1'b0;
    run_cycle();
    run_cycle();
    check_true(!pred_tar_vld, "pred_tar_vld held after the instruction was consumed");
    nx_fb = '0;
    probe(16'h4242, 1'b0, 1'b1, 16'h9a9a);
    wait_tar_vld();
    nx_fb.ctrl_chgflw_vld = 1'b1;
    run_cycle();
    run_cycle();
    check_true(!pred_tar_vld, "pred_tar_vld held across a controller redirect");
    nx_fb     = '0;
    fb_random = 1'b1;

    // Disabled buffer and IU redirect
    nx_en = 1'b0;
    do_update(16'h7000, 16'h1111);
    nx_en = 1'b1;
    probe(16'h7000, 1'b0, 1'b0, 16'h0);
    do_update(16'h7000, 16'h2222);
    nx_en = 1'b0;
    probe(16'h7000, 1'b0, 1'b0, 16'h0);
    nx_en = 1'b1;
    probe(16'h7000, 1'b1, 1'b0, 16'h0);
    probe(16'h7000, 1'b0, 1'b1, 16'h2222);

    // Fully random traffic against the model
    for (int k = 0; k < 400; k++)
    begin
      random_inputs();
      run_cycle();
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/btb_pc_pkg.sv
src/btb_ctrl_pkg.sv
src/btb_entry.sv
src/btb_write_ctrl.sv
src/btb_read_pred.sv
src/btb_top.sv
test/btb_clk_gen.sv
test/btb_tb.sv

// ==== Bender.yml ====
package:
  name: btb

sources:
  - include_dirs:
      - src
    files:
      - src/btb_pc_pkg.sv
      - src/btb_ctrl_pkg.sv
      - src/btb_entry.sv
      - src/btb_write_ctrl.sv
      - src/btb_read_pred.sv
      - src/btb_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/btb_clk_gen.sv
      - test/btb_tb.sv
